// File: rtl/cache_def.sv
package cache_def;

  // address split  tag 31:14 | index 13:4 | word 3:2 | byte 1:0
  localparam int OFFSET_BITS = 4;  // byte offset within a line
  localparam int TAGLSB      = 14; // lowest tag bit
  localparam int TAGMSB      = 31; // highest tag bit

  localparam int NUM_LINES = 1 << (TAGLSB - OFFSET_BITS); // 1024 lines

  typedef logic [31:0]  word_t; // one cpu word
  typedef logic [127:0] line_t; // four words per line
  typedef logic [31:0]  addr_t; // cpu byte address

  typedef logic [TAGMSB-TAGLSB:0]        tag_t;   // stored tag, 18 bits
  typedef logic [TAGLSB-OFFSET_BITS-1:0] index_t; // line index, 10 bits

  // controller states
  typedef enum logic [1:0] {
    idle,        // waiting for cpu_valid
    compare_tag, // hit check
    allocate,    // waiting for line fill
    write_back   // waiting for dirty line write
  } cache_state_t;

endpackage

// File: rtl/cache_if.sv
`timescale 1ns/1ps

interface tag_port_if;
  import cache_def::*;

  index_t index;  // line select
  logic   we;     // write strobe
  tag_t   wtag;   // tag to store
  logic   wvalid; // valid to store
  logic   wdirty; // dirty to store
  tag_t   rtag;   // stored tag
  logic   rvalid; // stored valid
  logic   rdirty; // stored dirty

  modport ctrl (output index, we, wtag, wvalid, wdirty, input rtag, rvalid, rdirty);
  modport ram (input index, we, wtag, wvalid, wdirty, output rtag, rvalid, rdirty);

endinterface

interface data_port_if;
  import cache_def::*;

  index_t index; // line select
  logic   we;    // write strobe
  line_t  wline; // line to store
  line_t  rline; // stored line, async

  modport ctrl (output index, we, wline, input rline);
  modport ram (input index, we, wline, output rline);

endinterface

interface mem_port_if;
  import cache_def::*;

  logic  req_valid; // one-cycle request strobe
  logic  req_rw;    // 1 = line write
  addr_t req_addr;  // line aligned byte address
  line_t req_data;  // write line
  logic  rsp_ready; // one-cycle done pulse
  line_t rsp_data;  // read line, valid with rsp_ready

  modport ctrl (output req_valid, req_rw, req_addr, req_data, input rsp_ready, rsp_data);
  modport mem (input req_valid, req_rw, req_addr, req_data, output rsp_ready, rsp_data);

endinterface

// File: rtl/cache_tag_ram.sv
`timescale 1ns/1ps

module cache_tag_ram (
  input logic      clk,
  input logic      rst,
  tag_port_if.ram  port
);
  import cache_def::*;

  tag_t                 tag_mem   [NUM_LINES]; // tag per line
  logic                 dirty_mem [NUM_LINES]; // dirty per line
  logic [NUM_LINES-1:0] valid_bits;            // only part with reset

  // async read from index
  assign port.rtag   = tag_mem[port.index];
  assign port.rdirty = dirty_mem[port.index];
  assign port.rvalid = valid_bits[port.index];

  // valid vector, all lines empty after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;
    end else if (port.we) begin
      valid_bits[port.index] <= port.wvalid;
    end
  end

  // tag and dirty written together with valid
  always_ff @(posedge clk) begin
    if (port.we) begin
      tag_mem[port.index]   <= port.wtag;
      dirty_mem[port.index] <= port.wdirty;
    end
  end

endmodule

// File: rtl/cache_data_ram.sv
`timescale 1ns/1ps

module cache_data_ram (
  input logic      clk,
  data_port_if.ram port
);
  import cache_def::*;

  line_t line_mem [NUM_LINES]; // 1024 x 128 line store

  assign port.rline = line_mem[port.index]; // async read

  always_ff @(posedge clk) begin
    if (port.we) begin
      line_mem[port.index] <= port.wline; // whole line at once
    end
  end

endmodule

// File: rtl/cache_fsm.sv
`timescale 1ns/1ps

module cache_fsm (
  input  logic             clk,
  input  logic             rst,
  input  logic             cpu_valid, // held until cpu_ready
  input  logic             cpu_rw,    // 1 = write
  input  cache_def::addr_t cpu_addr,
  input  cache_def::word_t cpu_wdata,
  output logic             cpu_ready, // one-cycle done pulse
  output cache_def::word_t cpu_rdata,
  tag_port_if.ctrl         tag,
  data_port_if.ctrl        data,
  mem_port_if.ctrl         mem
);
  import cache_def::*;

  localparam int WORD_W = $bits(word_t);

  cache_state_t state;      // current state
  cache_state_t next_state; // comb next state
  index_t       req_index;  // index of cpu request
  tag_t         req_tag;    // tag of cpu request
  logic [1:0]   word_sel;   // word within line
  logic         hit;        // valid and tag match
  line_t        merged;     // stored line with cpu word inserted

  assign req_index = cpu_addr[TAGLSB-1:OFFSET_BITS];
  assign req_tag   = cpu_addr[TAGMSB:TAGLSB];
  assign word_sel  = cpu_addr[OFFSET_BITS-1:2];

  assign tag.index  = req_index; // both stores always look at cpu line
  assign data.index = req_index;

  assign hit = tag.rvalid && (tag.rtag == req_tag);

  // read word out of current line
  assign cpu_rdata = data.rline[word_sel*WORD_W +: WORD_W];

  // write merge
  always_comb begin
    merged = data.rline;
    merged[word_sel*WORD_W +: WORD_W] = cpu_wdata;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    cpu_ready  = 1'b0;

    tag.we     = 1'b0;
    tag.wtag   = req_tag; // new tag on miss, same tag on hit
    tag.wvalid = 1'b1;
    tag.wdirty = 1'b0;

    data.we    = 1'b0;
    data.wline = merged;

    mem.req_valid = 1'b0;
    mem.req_rw    = 1'b0;
    mem.req_addr  = {cpu_addr[TAGMSB:OFFSET_BITS], {OFFSET_BITS{1'b0}}}; // fill address
    mem.req_data  = data.rline; // victim line for write-back

    case (state)
      idle: begin
        if (cpu_valid) next_state = compare_tag;
      end

      compare_tag: begin
        if (hit) begin
          cpu_ready  = 1'b1;
          next_state = idle;
          if (cpu_rw) begin // write hit
            tag.we     = 1'b1;
            tag.wdirty = 1'b1;
            data.we    = 1'b1;
          end
        end else begin
          // claim the line for the new tag now
          tag.we        = 1'b1;
          tag.wdirty    = cpu_rw;
          mem.req_valid = 1'b1;
          if (tag.rvalid && tag.rdirty) begin
            mem.req_rw   = 1'b1;
            mem.req_addr = {tag.rtag, req_index, {OFFSET_BITS{1'b0}}}; // old line address
            next_state   = write_back;
          end else begin
            next_state = allocate; // empty or clean victim
          end
        end
      end

      allocate: begin
        if (mem.rsp_ready) begin
          data.we    = 1'b1;
          data.wline = mem.rsp_data; // refill line
          next_state = compare_tag;  // retry, write miss merges here
        end
      end

      write_back: begin
        if (mem.rsp_ready) begin
          mem.req_valid = 1'b1; // fetch new line
          next_state    = allocate;
        end
      end

      default: next_state = idle;
    endcase
  end

endmodule

// File: rtl/main_mem.sv
`timescale 1ns/1ps

module main_mem #(
  parameter int MEM_LATENCY    = 4,  // response delay in cycles
  parameter int MEM_LINES_LOG2 = 12  // depth in lines, log2
) (
  input logic     clk,
  input logic     rst,
  mem_port_if.mem port
);
  import cache_def::*;

  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  line_t                     mem_array [2**MEM_LINES_LOG2]; // line storage
  logic [CNT_W-1:0]          count;     // cycles left, 0 = free
  logic                      pend_rw;   // held request kind
  logic [MEM_LINES_LOG2-1:0] pend_line; // held line number
  line_t                     pend_data; // held write line
  logic [MEM_LINES_LOG2-1:0] req_line;  // incoming line number

  assign req_line = port.req_addr[OFFSET_BITS +: MEM_LINES_LOG2]; // upper bits dropped

  // backing store starts out all zero
  initial begin
    for (int i = 0; i < 2**MEM_LINES_LOG2; i++) begin
      mem_array[i] = '0;
    end
  end

  // countdown and response strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      count          <= '0;
      port.rsp_ready <= 1'b0;
    end else begin
      port.rsp_ready <= 1'b0;
      if (count == CNT_W'(1)) begin
        count          <= '0;
        port.rsp_ready <= 1'b1; // done this cycle
      end else if (count != '0) begin
        count <= count - 1'b1;
      end else if (port.req_valid) begin
        count <= CNT_W'(MEM_LATENCY);
      end
    end
  end

  // capture request payload
  always_ff @(posedge clk) begin
    if (port.req_valid && count == '0) begin
      pend_rw   <= port.req_rw;
      pend_line <= req_line;
      pend_data <= port.req_data;
    end
  end

  // access happens when the count runs out
  always_ff @(posedge clk) begin
    if (count == CNT_W'(1)) begin
      if (pend_rw) begin
        mem_array[pend_line] <= pend_data;
      end else begin
        port.rsp_data <= mem_array[pend_line];
      end
    end
  end

endmodule

// File: rtl/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
  parameter int MEM_LATENCY    = 4,  // backing memory delay
  parameter int MEM_LINES_LOG2 = 12  // backing memory depth, log2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             cpu_valid,
  input  logic             cpu_rw,
  input  cache_def::addr_t cpu_addr,
  input  cache_def::word_t cpu_wdata,
  output logic             cpu_ready,
  output cache_def::word_t cpu_rdata
);

  tag_port_if  tag_bus ();  // fsm to tag store
  data_port_if data_bus (); // fsm to line store
  mem_port_if  mem_bus ();  // fsm to backing memory

  cache_fsm cache_fsm_i (
    .clk       (clk),
    .rst       (rst),
    .cpu_valid (cpu_valid),
    .cpu_rw    (cpu_rw),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_ready (cpu_ready),
    .cpu_rdata (cpu_rdata),
    .tag       (tag_bus.ctrl),
    .data      (data_bus.ctrl),
    .mem       (mem_bus.ctrl)
  );

  cache_tag_ram cache_tag_ram_i (
    .clk  (clk),
    .rst  (rst),
    .port (tag_bus.ram)
  );

  cache_data_ram cache_data_ram_i (
    .clk  (clk),
    .port (data_bus.ram)
  );

  main_mem #(
    .MEM_LATENCY    (MEM_LATENCY),
    .MEM_LINES_LOG2 (MEM_LINES_LOG2)
  ) main_mem_i (
    .clk  (clk),
    .rst  (rst),
    .port (mem_bus.mem)
  );

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int RST_CYCLES = 16 // rising edges with rst high
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // release away from the rising edge
  end

endmodule

// File: sim/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;
  import cache_def::*;

  localparam int MEM_LATENCY = 4;
  localparam int NUM_OPS     = 20; // entries in the stimulus file
  localparam int MAX_CYCLES  = 16 + NUM_OPS * (2 * MEM_LATENCY + 8) + 50;
  localparam int IDLE_CHECKS = 4;  // quiet cycles after reset

  logic  clk;
  logic  rst;
  logic  cpu_valid;
  logic  cpu_rw;
  addr_t cpu_addr;
  word_t cpu_wdata;
  logic  cpu_ready;
  word_t cpu_rdata;

  logic [103:0] ops [NUM_OPS]; // op | hit | addr | wdata | rdata
  int           cycles = 0;    // free running, for the timeout

  clk_gen clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  cache_top #(
    .MEM_LATENCY (MEM_LATENCY)
  ) cache_top_i (
    .clk       (clk),
    .rst       (rst),
    .cpu_valid (cpu_valid),
    .cpu_rw    (cpu_rw),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_ready (cpu_ready),
    .cpu_rdata (cpu_rdata)
  );

  // compare and stop on first mismatch
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one cpu request, held until cpu_ready
  task automatic run_op(input int n);
    logic [103:0] ent;
    int           lat;
    ent = ops[n];
    @(negedge clk);
    check("cpu_ready", cpu_ready, 1'b0); // gap cycle, no stray pulse
    cpu_valid = 1'b1;
    cpu_rw    = ent[100];
    cpu_addr  = ent[95:64];
    cpu_wdata = ent[63:32];
    lat = 0;
    do begin
      @(negedge clk); // outputs settled here
      lat++;
    end while (!cpu_ready);
    if (!ent[100]) begin
      check("cpu_rdata", cpu_rdata, ent[31:0]);
    end
    check("hit (ready 1 cycle after accept)", lat == 1, ent[96]);
    cpu_valid = 1'b0; // drop for at least one cycle
  endtask

  // run limit from the worst case per request
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    cpu_valid = 1'b0;
    cpu_rw    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    $readmemh("sim/cache_input.txt", ops);
    if ($isunknown(ops[NUM_OPS-1])) begin
      $display("stimulus file sim/cache_input.txt is missing or too short");
      $display("Simulation failed");
      $fatal(1, "bad stimulus file");
    end
    @(negedge rst);
    repeat (IDLE_CHECKS) begin
      @(negedge clk);
      check("cpu_ready", cpu_ready, 1'b0); // idle with valid low
    end
    for (int i = 0; i < NUM_OPS; i++) begin
      run_op(i);
    end
    @(negedge clk);
    check("cpu_ready", cpu_ready, 1'b0);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: verilog.f
rtl/cache_def.sv
rtl/cache_if.sv
rtl/cache_tag_ram.sv
rtl/cache_data_ram.sv
rtl/cache_fsm.sv
rtl/main_mem.sv
rtl/cache_top.sv
sim/clk_gen.sv
sim/tb_cache.sv

// File: sim/cache_input.txt
// op (0 read, 1 write) _ expected hit _ address _ write data _ expected read data
// index 0x010 lines: 0x0100 tag 0, 0x4100 tag 1, 0x8100 tag 2
0_0_00000200_00000000_00000000 // never written, zero from memory
0_1_00000204_00000000_00000000
1_0_00000100_11111111_00000000 // write miss to empty line
1_1_00000104_22222222_00000000
0_1_00000100_00000000_11111111
0_1_00000104_00000000_22222222
0_1_00000108_00000000_00000000 // untouched word keeps zero
1_0_00004100_33333333_00000000 // dirty victim written back
0_1_00004104_00000000_00000000
0_0_00000104_00000000_22222222 // refill after write-back
0_0_00004100_00000000_33333333
1_0_00008108_44444444_00000000
1_0_00000300_55555555_00000000
0_0_00000108_00000000_00000000
0_0_00008108_00000000_44444444
1_1_00008108_66666666_00000000
0_1_00008108_00000000_66666666
1_0_00004300_77777777_00000000 // evicts dirty 0x0300
0_0_00000300_00000000_55555555
0_0_00004300_00000000_77777777
